// ==== common/vpu_consts.svh ====
// fixed geometry of 32 regs x 4 words; funct3/funct6 cover only the kept OP-V subset
`ifndef VPU_CONSTS_SVH
`define VPU_CONSTS_SVH

// register file geometry
`define VPU_NREGS  32
`define VPU_VLEN   128
`define VPU_ELEN   32
`define VPU_VLMAX  (`VPU_VLEN / `VPU_ELEN)   // elements per register

`define VPU_AW     8    // word address into a 256-word memory

// funct3 operand source or config
`define VPU_F3_VV  3'b000
`define VPU_F3_VI  3'b011
`define VPU_F3_VX  3'b100
`define VPU_F3_CFG 3'b111

// funct6 element op
`define VPU_F6_ADD 6'b000000
`define VPU_F6_SUB 6'b000010
`define VPU_F6_AND 6'b001001
`define VPU_F6_OR  6'b001010
`define VPU_F6_XOR 6'b001011

`endif

// ==== common/vpu_pkg.sv ====
// types sized from vpu_consts.svh; vl_t is one bit wider than an element index to hold vl = 4
`default_nettype none

`include "vpu_consts.svh"

package vpu_pkg;

  typedef logic [`VPU_ELEN-1:0] elem_t;   // one element or a scalar
  typedef logic [`VPU_VLEN-1:0] vreg_t;

  typedef logic [$clog2(`VPU_NREGS)-1:0] vreg_idx_t;
  typedef logic [$clog2(`VPU_VLMAX)-1:0] elem_idx_t;

  // 0 .. VLMAX inclusive
  typedef logic [$clog2(`VPU_VLMAX):0] vl_t;

  typedef logic [`VPU_AW-1:0] mem_adr_t;

  typedef enum logic [2:0] {
    IDLE,
    CONFIG,
    LOAD,
    STORE,
    ARITH_INIT,     // one dead cycle before the element loop
    ARITH_LOOP
  } seq_state_e;

endpackage

`default_nettype wire

// ==== common/vreg_port_if.sv ====
// reads are combinational, the single write port commits on the clock edge
`timescale 1ns/1ps
`default_nettype none

interface vreg_port_if;
  import vpu_pkg::*;

  vreg_idx_t rd_idx_a;
  vreg_idx_t rd_idx_b;
  elem_idx_t rd_elem;    // shared by both read ports
  elem_t     rd_dat_a;
  elem_t     rd_dat_b;

  logic      we;
  vreg_idx_t wr_idx;
  elem_idx_t wr_elem;
  elem_t     wr_dat;

  modport seq (
    output rd_idx_a, rd_idx_b, rd_elem, we, wr_idx, wr_elem, wr_dat,
    input  rd_dat_a, rd_dat_b
  );

  modport rf (
    input  rd_idx_a, rd_idx_b, rd_elem, we, wr_idx, wr_elem, wr_dat,
    output rd_dat_a, rd_dat_b
  );

endinterface

`default_nettype wire

// ==== logic/vpu_vregfile.sv ====
// all 32 registers clear on reset; a read of the element being written returns the old value
`timescale 1ns/1ps
`default_nettype none

`include "vpu_consts.svh"

module vpu_vregfile (
  input  logic           i_clk,
  input  logic           i_rst_n,
  vreg_port_if.rf        rp
);
  import vpu_pkg::*;

  vreg_t regs [`VPU_NREGS];

  vreg_t rd_reg_a;
  vreg_t rd_reg_b;

  function automatic elem_t elem_sel(input vreg_t r, input elem_idx_t e);
    elem_t res;
    res = r[e*`VPU_ELEN +: `VPU_ELEN];
    return res;
  endfunction

  // two read ports at the same element position
  assign rd_reg_a = regs[rp.rd_idx_a];
  assign rd_reg_b = regs[rp.rd_idx_b];

  assign rp.rd_dat_a = elem_sel(rd_reg_a, rp.rd_elem);
  assign rp.rd_dat_b = elem_sel(rd_reg_b, rp.rd_elem);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int r = 0; r < `VPU_NREGS; r++) begin
        regs[r] <= '0;
      end
    end else if (rp.we) begin
      regs[rp.wr_idx][rp.wr_elem*`VPU_ELEN +: `VPU_ELEN] <= rp.wr_dat;   // one word only
    end
  end

  // write data comes from memory or the ALU lane
  a_wr_dat_known: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    rp.we |-> !$isunknown({rp.wr_idx, rp.wr_elem, rp.wr_dat})
  ) else $error("vregfile: unknown write while we is high");

endmodule

`default_nettype wire

// ==== logic/vpu_alu_lane.sv ====
// one 32-bit element per call; the immediate is zero-extended, sub is vs2 minus operand
`timescale 1ns/1ps
`default_nettype none

`include "vpu_consts.svh"

module vpu_alu_lane (
  input  vpu_pkg::elem_t     i_vs1_dat,
  input  vpu_pkg::elem_t     i_vs2_dat,
  input  vpu_pkg::elem_t     i_rs1,
  input  vpu_pkg::vreg_idx_t i_imm,      // vs1 field
  input  logic [2:0]         i_funct3,
  input  logic [5:0]         i_funct6,
  output vpu_pkg::elem_t     o_res,
  output logic               o_ok
);
  import vpu_pkg::*;

  elem_t opnd;
  logic  src_ok;

  // second operand source
  always_comb begin
    src_ok = 1'b1;
    case (i_funct3)
      `VPU_F3_VV: opnd = i_vs1_dat;
      `VPU_F3_VX: opnd = i_rs1;
      `VPU_F3_VI: opnd = elem_t'(i_imm);   // zero-extend
      default: begin
        opnd   = i_vs1_dat;
        src_ok = 1'b0;
      end
    endcase
  end

  always_comb begin
    o_ok = src_ok;
    case (i_funct6)
      `VPU_F6_ADD: o_res = i_vs2_dat + opnd;
      `VPU_F6_SUB: o_res = i_vs2_dat - opnd;
      `VPU_F6_AND: o_res = i_vs2_dat & opnd;
      `VPU_F6_OR:  o_res = i_vs2_dat | opnd;
      `VPU_F6_XOR: o_res = i_vs2_dat ^ opnd;
      default: begin
        o_res = '0;
        o_ok  = 1'b0;   // sequencer drops the write
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/vpu_sequencer.sv ====
// one instruction at a time; fields must hold until o_rdy; memory answers reads one cycle late
`timescale 1ns/1ps
`default_nettype none

`include "vpu_consts.svh"

module vpu_sequencer (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_valid,
  input  logic               i_load,
  input  logic               i_store,
  input  logic               i_vector_op,
  input  logic [2:0]         i_funct3,
  input  logic [5:0]         i_funct6,
  input  vpu_pkg::elem_t     i_rs1,
  input  vpu_pkg::vreg_idx_t i_vd,
  input  vpu_pkg::vreg_idx_t i_vs1,
  input  vpu_pkg::vreg_idx_t i_vs2,
  input  vpu_pkg::elem_t     i_mem_rdat,
  input  vpu_pkg::elem_t     i_alu_res,
  input  logic               i_alu_ok,
  vreg_port_if.seq           vp,
  output logic               o_mem_req,
  output logic               o_mem_we,
  output vpu_pkg::mem_adr_t  o_mem_adr,
  output vpu_pkg::elem_t     o_mem_wdat,
  output logic               o_rdy,
  output vpu_pkg::vl_t       o_vl
);
  import vpu_pkg::*;

  seq_state_e state_q;
  seq_state_e state_d;

  vl_t       vl_q;
  vl_t       cnt_q;       // current element
  mem_adr_t  adr_q;
  logic      ld_pend_q;   // read issued last cycle
  elem_idx_t ld_elem_q;

  elem_idx_t cur_elem;
  logic      more;        // elements left below vl
  logic      last;        // current element is the final one
  logic      mem_cyc;

  assign cur_elem = elem_idx_t'(cnt_q);
  assign more     = (cnt_q < vl_q);
  assign last     = ((cnt_q + 1'b1) >= vl_q);
  assign mem_cyc  = (state_q == LOAD) || (state_q == STORE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (i_valid) begin
          if (i_load) begin
            state_d = LOAD;
          end else if (i_store) begin
            state_d = STORE;
          end else if (i_vector_op && (i_funct3 == `VPU_F3_CFG)) begin
            state_d = CONFIG;
          end else if (i_vector_op) begin
            state_d = ARITH_INIT;
          end
        end
      end
      CONFIG:     state_d = IDLE;
      LOAD:       if (!more) state_d = IDLE;   // last write lands here
      STORE:      if (last) state_d = IDLE;
      ARITH_INIT: state_d = (vl_q == '0) ? IDLE : ARITH_LOOP;
      ARITH_LOOP: if (last) state_d = IDLE;
      default:    state_d = IDLE;
    endcase
  end

  // completion strobe on the final busy cycle
  assign o_rdy = (state_q != IDLE) && (state_d == IDLE);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q   <= IDLE;
      vl_q      <= '0;
      cnt_q     <= '0;
      adr_q     <= '0;
      ld_pend_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      ld_pend_q <= (state_q == LOAD) && more;
      case (state_q)
        IDLE: begin
          cnt_q <= '0;
          if (i_valid) begin
            adr_q <= mem_adr_t'(i_rs1);   // word base
          end
        end
        CONFIG: begin
          vl_q <= (i_rs1 > elem_t'(`VPU_VLMAX)) ? vl_t'(`VPU_VLMAX) : vl_t'(i_rs1);
        end
        LOAD, STORE: begin
          if (more) begin
            cnt_q <= cnt_q + 1'b1;
            adr_q <= adr_q + 1'b1;
          end
        end
        ARITH_LOOP: cnt_q <= cnt_q + 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    ld_elem_q <= cur_elem;   // lines up with returning read data
  end

  assign o_mem_req  = mem_cyc && more;
  assign o_mem_we   = (state_q == STORE) && more;
  assign o_mem_adr  = adr_q;
  assign o_mem_wdat = vp.rd_dat_b;   // vd element during store
  assign o_vl       = vl_q;

  assign vp.rd_idx_a = i_vs1;
  assign vp.rd_idx_b = (state_q == STORE) ? i_vd : i_vs2;
  assign vp.rd_elem  = cur_elem;

  assign vp.wr_idx  = i_vd;
  assign vp.wr_elem = (state_q == LOAD) ? ld_elem_q : cur_elem;
  assign vp.wr_dat  = (state_q == LOAD) ? i_mem_rdat : i_alu_res;
  assign vp.we      = ((state_q == LOAD) && ld_pend_q) ||
                      ((state_q == ARITH_LOOP) && more && i_alu_ok);

  a_we_has_req: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    o_mem_we |-> o_mem_req
  ) else $error("sequencer: memory write without request");

  // delayed load index included
  a_wr_below_vl: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    vp.we |-> (vl_t'(vp.wr_elem) < vl_q)
  ) else $error("sequencer: write to element at or beyond vl");

  a_fields_held: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (state_q != IDLE) |-> $stable({i_load, i_store, i_vector_op, i_funct3, i_funct6,
                                   i_rs1, i_vd, i_vs1, i_vs2})
  ) else $error("sequencer: instruction fields changed while busy");

endmodule

`default_nettype wire

// ==== logic/vpu_top.sv ====
// no back-pressure anywhere; i_valid is ignored while busy, fields held until o_rdy
`timescale 1ns/1ps
`default_nettype none

module vpu_top (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_valid,
  input  logic               i_load,
  input  logic               i_store,
  input  logic               i_vector_op,
  input  logic [2:0]         i_funct3,
  input  logic [5:0]         i_funct6,
  input  vpu_pkg::elem_t     i_rs1,
  input  vpu_pkg::vreg_idx_t i_vd,
  input  vpu_pkg::vreg_idx_t i_vs1,
  input  vpu_pkg::vreg_idx_t i_vs2,
  input  vpu_pkg::elem_t     i_mem_rdat,
  output logic               o_mem_req,
  output logic               o_mem_we,
  output vpu_pkg::mem_adr_t  o_mem_adr,
  output vpu_pkg::elem_t     o_mem_wdat,
  output logic               o_rdy,
  output vpu_pkg::vl_t       o_vl
);
  import vpu_pkg::*;

  elem_t alu_res;
  logic  alu_ok;

  vreg_port_if vp ();

  vpu_sequencer u_seq (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_valid     (i_valid),
    .i_load      (i_load),
    .i_store     (i_store),
    .i_vector_op (i_vector_op),
    .i_funct3    (i_funct3),
    .i_funct6    (i_funct6),
    .i_rs1       (i_rs1),
    .i_vd        (i_vd),
    .i_vs1       (i_vs1),
    .i_vs2       (i_vs2),
    .i_mem_rdat  (i_mem_rdat),
    .i_alu_res   (alu_res),
    .i_alu_ok    (alu_ok),
    .vp          (vp.seq),
    .o_mem_req   (o_mem_req),
    .o_mem_we    (o_mem_we),
    .o_mem_adr   (o_mem_adr),
    .o_mem_wdat  (o_mem_wdat),
    .o_rdy       (o_rdy),
    .o_vl        (o_vl)
  );

  // operands straight off the register file read ports
  vpu_alu_lane u_alu (
    .i_vs1_dat (vp.rd_dat_a),
    .i_vs2_dat (vp.rd_dat_b),
    .i_rs1     (i_rs1),
    .i_imm     (i_vs1),
    .i_funct3  (i_funct3),
    .i_funct6  (i_funct6),
    .o_res     (alu_res),
    .o_ok      (alu_ok)
  );

  vpu_vregfile u_rf (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .rp      (vp.rf)
  );

endmodule

`default_nettype wire

// ==== verification/tb_vpu.sv ====
// directed tests at 40 ns; memory answers reads one cycle late; results are read back through store
`timescale 1ns/1ps
`default_nettype none

`include "vpu_consts.svh"

module tb_vpu;
  import vpu_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int OP_CYC       = `VPU_VLMAX + 4;   // longest o_rdy latency plus slack
  localparam int MAX_OPS      = 48;
  localparam int WATCHDOG_CYC = 16 + MAX_OPS * (OP_CYC + 3) + 100;

  logic                i_clk = 1'b0;
  logic                i_rst_n;
  logic                i_valid;
  logic                i_load;
  logic                i_store;
  logic                i_vector_op;
  logic [2:0]          i_funct3;
  logic [5:0]          i_funct6;
  elem_t               i_rs1;
  logic [4:0]          i_vd;
  logic [4:0]          i_vs1;
  logic [4:0]          i_vs2;
  elem_t               i_mem_rdat;
  logic                o_mem_req;
  logic                o_mem_we;
  logic [`VPU_AW-1:0]  o_mem_adr;
  elem_t               o_mem_wdat;
  logic                o_rdy;
  logic [2:0]          o_vl;

  elem_t               mem [0:255];
  logic [`VPU_AW:0]    req_log [$];   // {we, address} per request
  int                  seed;
  int                  cur_vl;
  int                  err_cnt;
  int                  tests_run;
  int                  tests_failed;
  int                  test_err_start;
  string               cur_test;

  vpu_top i_dut (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_valid     (i_valid),
    .i_load      (i_load),
    .i_store     (i_store),
    .i_vector_op (i_vector_op),
    .i_funct3    (i_funct3),
    .i_funct6    (i_funct6),
    .i_rs1       (i_rs1),
    .i_vd        (i_vd),
    .i_vs1       (i_vs1),
    .i_vs2       (i_vs2),
    .i_mem_rdat  (i_mem_rdat),
    .o_mem_req   (o_mem_req),
    .o_mem_we    (o_mem_we),
    .o_mem_adr   (o_mem_adr),
    .o_mem_wdat  (o_mem_wdat),
    .o_rdy       (o_rdy),
    .o_vl        (o_vl)
  );

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  // word memory with one cycle read latency
  initial begin
    seed = 32'h82c6;
    i_mem_rdat <= '0;
    for (int a = 0; a < 256; a++) begin
      mem[8'(a)] = elem_t'($random(seed));
    end
    forever begin
      @(posedge i_clk);
      if (o_mem_req && !o_mem_we) begin
        i_mem_rdat <= mem[o_mem_adr];
      end
      if (o_mem_req && o_mem_we) begin
        mem[o_mem_adr] = o_mem_wdat;
      end
      if (o_mem_req) begin
        req_log.push_back({o_mem_we, o_mem_adr});
      end
    end
  end

  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

  function automatic logic [`VPU_AW-1:0] adr_at(input logic [`VPU_AW-1:0] base, input int i);
    return base + `VPU_AW'(i);
  endfunction

  function automatic elem_t expect_op(input logic [5:0] f6, input elem_t a, input elem_t b);
    case (f6)
      `VPU_F6_ADD: return a + b;
      `VPU_F6_SUB: return a - b;   // vs2 minus operand
      `VPU_F6_AND: return a & b;
      `VPU_F6_OR:  return a | b;
      `VPU_F6_XOR: return a ^ b;
      default:     return a;
    endcase
  endfunction

  task automatic compare_word(input string what, input elem_t exp, input elem_t act);
    if (exp !== act) begin
      $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_err_start = err_cnt;
  endtask

  task automatic end_test();
    tests_run++;
    if (err_cnt == test_err_start) begin
      $display("PASS %s", cur_test);
    end else begin
      tests_failed++;
      $display("FAIL %s with %0d errors", cur_test, err_cnt - test_err_start);
    end
  endtask

  // runs one instruction and returns cycles from the i_valid sampling edge to o_rdy
  task automatic run_instr(input logic ld, input logic st, input logic vop, input logic [2:0] f3,
                           input logic [5:0] f6, input elem_t rs1, input logic [4:0] vd,
                           input logic [4:0] vs1, input logic [4:0] vs2, output int cycles);
    int  cyc;
    logic seen;
    @(posedge i_clk);
    i_load      <= ld;
    i_store     <= st;
    i_vector_op <= vop;
    i_funct3    <= f3;
    i_funct6    <= f6;
    i_rs1       <= rs1;
    i_vd        <= vd;
    i_vs1       <= vs1;
    i_vs2       <= vs2;
    i_valid     <= 1'b1;
    @(posedge i_clk);
    i_valid <= 1'b0;
    cyc  = 0;
    seen = 1'b0;
    while (!seen && cyc < OP_CYC) begin
      @(negedge i_clk);
      cyc++;
      seen = o_rdy;
    end
    if (!seen) begin
      $display("%s: o_rdy did not arrive within %0d cycles of i_valid", cur_test, OP_CYC);
      err_cnt++;
    end
    @(negedge i_clk);   // last writes have landed
    compare_word("o_rdy one cycle wide", '0, elem_t'(o_rdy));
    cycles = cyc;
  endtask

  task automatic check_requests(input int first, input logic [`VPU_AW-1:0] base, input logic we);
    compare_word("request count", elem_t'(cur_vl), elem_t'(req_log.size() - first));
    for (int i = 0; i < cur_vl && first + i < req_log.size(); i++) begin
      compare_word($sformatf("request %0d", i), elem_t'({we, adr_at(base, i)}),
                   elem_t'(req_log[first + i]));
    end
  endtask

  task automatic set_vl(input elem_t avl, input int exp_vl);
    int cyc;
    run_instr(1'b0, 1'b0, 1'b1, `VPU_F3_CFG, 6'd0, avl, 5'd0, 5'd0, 5'd0, cyc);
    cur_vl = exp_vl;
    compare_word($sformatf("config %0d cycles", avl), 32'd1, elem_t'(cyc));
    compare_word($sformatf("config %0d vl", avl), elem_t'(exp_vl), elem_t'(o_vl));
  endtask

  task automatic load_vreg(input logic [4:0] vd, input logic [`VPU_AW-1:0] base);
    int cyc;
    int first;
    first = req_log.size();
    run_instr(1'b1, 1'b0, 1'b0, 3'd0, 6'd0, elem_t'(base), vd, 5'd0, 5'd0, cyc);
    compare_word("load cycles", elem_t'(cur_vl + 1), elem_t'(cyc));
    check_requests(first, base, 1'b0);
  endtask

  task automatic store_vreg(input logic [4:0] vd, input logic [`VPU_AW-1:0] base);
    int cyc;
    int first;
    first = req_log.size();
    run_instr(1'b0, 1'b1, 1'b0, 3'd0, 6'd0, elem_t'(base), vd, 5'd0, 5'd0, cyc);
    compare_word("store cycles", elem_t'((cur_vl > 1) ? cur_vl : 1), elem_t'(cyc));
    check_requests(first, base, 1'b1);
  endtask

  task automatic exec_arith(input logic [2:0] f3, input logic [5:0] f6, input elem_t rs1,
                            input logic [4:0] vd, input logic [4:0] vs1, input logic [4:0] vs2);
    int cyc;
    int first;
    first = req_log.size();
    run_instr(1'b0, 1'b0, 1'b1, f3, f6, rs1, vd, vs1, vs2, cyc);
    compare_word("arith cycles", elem_t'(cur_vl + 1), elem_t'(cyc));
    compare_word("arith memory requests", '0, elem_t'(req_log.size() - first));
  endtask

  initial begin
    logic [5:0] ops [5];
    logic [`VPU_AW-1:0] src;
    elem_t scalar;
    i_rst_n     <= 1'b0;
    i_valid     <= 1'b0;
    i_load      <= 1'b0;
    i_store     <= 1'b0;
    i_vector_op <= 1'b0;
    i_funct3    <= '0;
    i_funct6    <= '0;
    i_rs1       <= '0;
    i_vd        <= '0;
    i_vs1       <= '0;
    i_vs2       <= '0;
    ops = '{`VPU_F6_ADD, `VPU_F6_SUB, `VPU_F6_AND, `VPU_F6_OR, `VPU_F6_XOR};
    repeat (16) @(posedge i_clk);
    i_rst_n <= 1'b1;
    @(negedge i_clk);

    start_test("reset_state");
    compare_word("o_rdy", '0, elem_t'(o_rdy));
    compare_word("o_mem_req", '0, elem_t'(o_mem_req));
    compare_word("o_mem_we", '0, elem_t'(o_mem_we));
    compare_word("o_vl", '0, elem_t'(o_vl));
    set_vl(32'd4, 4);
    store_vreg(5'd31, 8'hf0);   // cleared register reads back as zero
    for (int i = 0; i < 4; i++) begin
      compare_word($sformatf("v31 elem %0d", i), '0, mem[adr_at(8'hf0, i)]);
    end
    end_test();

    start_test("configure");
    set_vl(32'd3, 3);
    set_vl(32'd9, 4);
    set_vl(32'd0, 0);
    end_test();

    start_test("load_store");
    set_vl(32'd4, 4);
    load_vreg(5'd5, 8'h10);
    store_vreg(5'd5, 8'h80);
    for (int i = 0; i < 4; i++) begin
      compare_word($sformatf("copy elem %0d", i), mem[adr_at(8'h10, i)], mem[adr_at(8'h80, i)]);
    end
    set_vl(32'd2, 2);
    load_vreg(5'd5, 8'h20);   // elements 2 and 3 keep the first load
    set_vl(32'd4, 4);
    store_vreg(5'd5, 8'h84);
    for (int i = 0; i < 4; i++) begin
      compare_word($sformatf("partial elem %0d", i),
                   (i < 2) ? mem[adr_at(8'h20, i)] : mem[adr_at(8'h10, i)],
                   mem[adr_at(8'h84, i)]);
    end
    end_test();

    start_test("vv_arith");
    for (int k = 0; k < 5; k++) begin
      src = 8'h30 + 8'(8 * k);
      load_vreg(5'(1 + k), src);
      load_vreg(5'(10 + k), src + 8'h4);
      exec_arith(`VPU_F3_VV, ops[k], '0, 5'(20 + k), 5'(1 + k), 5'(10 + k));
      store_vreg(5'(20 + k), 8'h90 + 8'(4 * k));
      for (int i = 0; i < 4; i++) begin
        compare_word($sformatf("op %0d elem %0d", k, i),
                     expect_op(ops[k], mem[adr_at(src + 8'h4, i)], mem[adr_at(src, i)]),
                     mem[adr_at(8'h90 + 8'(4 * k), i)]);
      end
    end
    end_test();

    start_test("vx_vi_arith");
    scalar = mem[8'hf8];
    exec_arith(`VPU_F3_VX, `VPU_F6_ADD, scalar, 5'd25, 5'd0, 5'd14);
    store_vreg(5'd25, 8'ha8);
    exec_arith(`VPU_F3_VI, `VPU_F6_SUB, '0, 5'd26, 5'd19, 5'd14);
    store_vreg(5'd26, 8'hb0);
    for (int i = 0; i < 4; i++) begin
      compare_word($sformatf("vx elem %0d", i), mem[adr_at(8'h54, i)] + scalar,
                   mem[adr_at(8'ha8, i)]);
      compare_word($sformatf("vi elem %0d", i), mem[adr_at(8'h54, i)] - 32'd19,
                   mem[adr_at(8'hb0, i)]);
    end
    end_test();

    start_test("unknown_funct6");
    exec_arith(`VPU_F3_VV, 6'b111111, '0, 5'd24, 5'd5, 5'd14);
    store_vreg(5'd24, 8'hb8);   // v24 still holds the xor result
    for (int i = 0; i < 4; i++) begin
      compare_word($sformatf("vd elem %0d", i), mem[adr_at(8'ha0, i)], mem[adr_at(8'hb8, i)]);
    end
    end_test();

    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+common
common/vpu_pkg.sv
common/vreg_port_if.sv
logic/vpu_vregfile.sv
logic/vpu_alu_lane.sv
logic/vpu_sequencer.sv
logic/vpu_top.sv
verification/tb_vpu.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_vpu -Mdir obj_dir -o sim_vpu
./obj_dir/sim_vpu > sim.log
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
